// ==== dv/cgra_ctrl_tests.txt ====
// a line with one value starts a test and gives REG_MAX, ff ends the list
// context lines (hex): n_max y_max k_max j_max op stride src_bank dst_bank st_addr
0
1 1 1 2 0 0 1 2 10
2
0 2 1 1 0 1 2 3 20
1 1 0 1 1 0 0 1 30
1 0 2 0 0 0 3 0 40
1
0 0 0 0 3 0 1 1 50
2 1 1 1 0 1 0 2 60
ff

// ==== vlog.f ====
+incdir+dv
logic/ctrl_pkg.sv
logic/apb_pkg.sv
logic/apb_regs.sv
logic/layer_fsm.sv
logic/loop_counter.sv
logic/weight_bias_addr.sv
logic/ldm_addr_gen.sv
logic/cgra_ctrl_top.sv
dv/cgra_ctrl_tb.sv

// ==== dv/cgra_ctrl_tb_tasks.svh ====
// ####################################################################
// APB access tasks, one run per test and expected values of a layer
// ####################################################################
`ifndef CGRA_CTRL_TB_TASKS_SVH
`define CGRA_CTRL_TB_TASKS_SVH

// entered on a falling edge, leaves on the falling edge after the access
task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
	apb_req.psel    = 1'b1;
	apb_req.penable = 1'b0;
	apb_req.pwrite  = 1'b1;
	apb_req.paddr   = addr;
	apb_req.pwdata  = data;
	@(negedge CLK);
	apb_req.penable = 1'b1;
	#1;
	err = apb_rsp.pslverr;
	@(negedge CLK);
	apb_req = '0;
endtask

task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
	apb_req.psel    = 1'b1;
	apb_req.penable = 1'b0;
	apb_req.pwrite  = 1'b0;
	apb_req.paddr   = addr;
	apb_req.pwdata  = '0;
	@(negedge CLK);
	apb_req.penable = 1'b1;
	#1;
	data = apb_rsp.prdata;
	err  = apb_rsp.pslverr;
	@(negedge CLK);
	apb_req = '0;
endtask

// walks the n/y/k/j nest of one layer on the registered memory ports
task automatic check_layer(input ctx_word_t c, input logic last);
	int                     t;
	int                     n;
	int                     y;
	int                     k;
	int                     j;
	int                     sweep;
	int                     gap;
	logic                   is_mac;
	logic                   b_en;
	logic [LDM_ADDR_W-1:0]  row;
	logic [WRAM_ADDR_W-1:0] w_exp;
	is_mac = (c.op == OP_MAC);
	sweep  = 0;
	t      = 0;
	while (ldm_rd.en !== 1'b1 && t < WAIT_LIMIT) begin
		@(negedge CLK);
		t++;
	end
	if (ldm_rd.en !== 1'b1) begin
		$display("timeout at %0t ns: no LDM read started for the layer", $time);
		timed_out = 1'b1;
		return;
	end
	for (n = 0; n <= int'(c.n_max); n++) begin
		for (y = 0; y <= int'(c.y_max); y++) begin
			for (k = 0; k <= int'(c.k_max); k++) begin
				for (j = 0; j <= int'(c.j_max); j++) begin
					if (is_mac) begin
						row = LDM_ADDR_W'(y * (1 + c.stride)
							+ k * ((int'(c.y_max) + 1) << c.stride));
					end else begin
						row = LDM_ADDR_W'(sweep);
					end
					w_exp = WRAM_ADDR_W'(w_base_exp
						+ n * (int'(c.k_max) + 1) * (int'(c.j_max) + 1)
						+ k * (int'(c.j_max) + 1) + j);
					b_en = is_mac && (k == int'(c.k_max)) && (j == int'(c.j_max));
					if (ldm_rd.en !== 1'b1) report_mismatch("ldm_rd.en", ldm_rd.en, 1);
					if (ldm_rd.addr_a.bank !== c.src_bank)
						report_mismatch("ldm_rd.addr_a.bank", ldm_rd.addr_a.bank, c.src_bank);
					if (ldm_rd.addr_a.row !== row)
						report_mismatch("ldm_rd.addr_a.row", ldm_rd.addr_a.row, row);
					if (ldm_rd.addr_b.bank !== c.src_bank)
						report_mismatch("ldm_rd.addr_b.bank", ldm_rd.addr_b.bank, c.src_bank);
					if (ldm_rd.addr_b.row !== LDM_ADDR_W'(row + 1))
						report_mismatch("ldm_rd.addr_b.row", ldm_rd.addr_b.row, row + 1);
					if (ldm_store.dst_bank !== c.dst_bank)
						report_mismatch("ldm_store.dst_bank", ldm_store.dst_bank, c.dst_bank);
					if (ldm_store.st_addr !== c.st_addr)
						report_mismatch("ldm_store.st_addr", ldm_store.st_addr, c.st_addr);
					if (pe_ctl.en !== 1'b1) report_mismatch("pe_ctl.en", pe_ctl.en, 1);
					if (pe_ctl.op !== c.op) report_mismatch("pe_ctl.op", pe_ctl.op, c.op);
					if (pe_ctl.stride !== c.stride)
						report_mismatch("pe_ctl.stride", pe_ctl.stride, c.stride);
					if (wram_rd.en !== is_mac) report_mismatch("wram_rd.en", wram_rd.en, is_mac);
					if (is_mac && wram_rd.addr !== w_exp)
						report_mismatch("wram_rd.addr", wram_rd.addr, w_exp);
					if (bram_rd.en !== b_en) report_mismatch("bram_rd.en", bram_rd.en, b_en);
					if (b_en && bram_rd.addr !== BRAM_ADDR_W'(b_base_exp + n))
						report_mismatch("bram_rd.addr", bram_rd.addr, b_base_exp + n);
					if (layer_done !== 1'b0) report_mismatch("layer_done", layer_done, 0);
					@(negedge CLK);
					if (j == int'(c.j_max)) sweep++;
				end
			end
		end
	end
	// the ports lag the iteration by one cycle, so done comes DRAIN_CYCLES-1 later
	gap = 1;
	while (layer_done !== 1'b1 && gap < WAIT_LIMIT) begin
		if (ldm_rd.en !== 1'b0) report_mismatch("ldm_rd.en", ldm_rd.en, 0);
		if (wram_rd.en !== 1'b0) report_mismatch("wram_rd.en", wram_rd.en, 0);
		if (bram_rd.en !== 1'b0) report_mismatch("bram_rd.en", bram_rd.en, 0);
		@(negedge CLK);
		gap++;
	end
	if (layer_done !== 1'b1) begin
		$display("timeout at %0t ns: layer_done never arrived", $time);
		timed_out = 1'b1;
		return;
	end
	if (gap != DRAIN_CYCLES - 1) report_mismatch("layer_done gap", gap, DRAIN_CYCLES - 1);
	if (complete !== last) report_mismatch("complete", complete, last);
	if (is_mac) begin
		w_base_exp += (int'(c.n_max) + 1) * (int'(c.k_max) + 1) * (int'(c.j_max) + 1);
		b_base_exp += int'(c.n_max) + 1;
	end
	@(negedge CLK);
endtask

task automatic run_test(input int max_a);
	int          gap;
	int          l;
	logic [31:0] rd;
	logic        err;
	test_errs  = 0;
	w_base_exp = 0;
	b_base_exp = 0;
	fetch_log.delete();
	gap = ($random(seed) & 7) + 1;
	repeat (gap) @(negedge CLK);
	apb_write(REG_MAX, max_a, err);
	if (err !== 1'b0) report_mismatch("pslverr", err, 0);
	apb_read(REG_MAX, rd, err);
	if (rd !== max_a) report_mismatch("REG_MAX", rd, max_a);
	apb_write(REG_CTRL, 32'h1, err);
	if (err !== 1'b0) report_mismatch("pslverr", err, 0);
	// lands while the run is still loading its first context
	apb_write(REG_CTRL, 32'h1, err);
	if (err !== 1'b1) report_mismatch("pslverr", err, 1);
	for (l = 0; l <= max_a; l++) begin
		check_layer(ctx_mem[l], l == max_a);
		if (timed_out) return;
	end
	if (fetch_log.size() != max_a + 1) begin
		report_mismatch("context fetch count", fetch_log.size(), max_a + 1);
	end else begin
		for (l = 0; l <= max_a; l++) begin
			if (fetch_log[l] != l) report_mismatch("cram_rd.addr", fetch_log[l], l);
		end
	end
	apb_read(REG_STATUS, rd, err);
	if (rd !== 32'h2) report_mismatch("REG_STATUS", rd, 2);
endtask

`endif

// ==== dv/cgra_ctrl_tb.sv ====
// ####################################################################
// testbench top: clock, reset, context RAM model, test loop and
// closing report for the layer sequencer
// ####################################################################
`timescale 1ns/1ps

module cgra_ctrl_tb;
	import ctrl_pkg::*;
	import apb_pkg::*;

	localparam int DRAIN_CYCLES = 3;
	localparam int WAIT_LIMIT   = 200;

	logic                   CLK;
	logic                   RST;
	apb_req_t               apb_req;
	apb_rsp_t               apb_rsp;
	cram_rd_t               cram_rd;
	ctx_word_t              ctx_in;
	pe_ctl_t                pe_ctl;
	wram_rd_t               wram_rd;
	bram_rd_t               bram_rd;
	ldm_rd_t                ldm_rd;
	ldm_store_t             ldm_store;
	logic                   layer_done;
	logic                   complete;

	logic [7:0]             tdata [0:255];
	ctx_word_t              ctx_mem [0:(1<<CRAM_ADDR_W)-1];
	logic                   rd_pend;
	logic [CRAM_ADDR_W-1:0] rd_addr;
	int                     fetch_log [$];
	int                     w_base_exp;
	int                     b_base_exp;
	int                     err_total;
	int                     test_errs;
	int                     tests_run;
	int                     tests_ok;
	logic                   timed_out;
	integer                 seed;

	cgra_ctrl_top #(
		.DRAIN_CYCLES (DRAIN_CYCLES)
	) UUT (
		.CLK        (CLK),
		.RST        (RST),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.cram_rd    (cram_rd),
		.ctx_in     (ctx_in),
		.pe_ctl     (pe_ctl),
		.wram_rd    (wram_rd),
		.bram_rd    (bram_rd),
		.ldm_rd     (ldm_rd),
		.ldm_store  (ldm_store),
		.layer_done (layer_done),
		.complete   (complete)
	);

	always #2 CLK = ~CLK;

	// context RAM, word appears one cycle after the enable
	always @(negedge CLK) begin
		if (rd_pend) begin
			ctx_in <= ctx_mem[rd_addr];
		end
		rd_pend <= cram_rd.en;
		rd_addr <= cram_rd.addr;
		if (cram_rd.en === 1'b1) begin
			fetch_log.push_back(int'(cram_rd.addr));
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
		err_total++;
		test_errs++;
	endtask

	// nine fields per context line of the data file
	function automatic ctx_word_t unpack_ctx(input int p);
		ctx_word_t c;
		c.rsvd     = 2'b00;
		c.n_max    = tdata[p][CNT_W-1:0];
		c.y_max    = tdata[p+1][ROW_W-1:0];
		c.k_max    = tdata[p+2][CNT_W-1:0];
		c.j_max    = tdata[p+3][CNT_W-1:0];
		c.op       = ctx_op_e'(tdata[p+4][1:0]);
		c.stride   = tdata[p+5][0];
		c.src_bank = tdata[p+6][BANK_W-1:0];
		c.dst_bank = tdata[p+7][BANK_W-1:0];
		c.st_addr  = tdata[p+8];
		return c;
	endfunction

	`include "cgra_ctrl_tb_tasks.svh"

	initial begin
		int          p;
		int          l;
		int          max_a;
		logic [31:0] rd;
		logic        err;
		CLK        = 1'b0;
		RST        = 1'b0;
		apb_req    = '0;
		ctx_in     = '0;
		rd_pend    = 1'b0;
		rd_addr    = '0;
		err_total  = 0;
		test_errs  = 0;
		tests_run  = 0;
		tests_ok   = 0;
		timed_out  = 1'b0;
		seed       = 32'h6a2c_500e;
		$readmemh("dv/cgra_ctrl_tests.txt", tdata);
		repeat (16) @(negedge CLK);
		RST = 1'b1;
		@(negedge CLK);
		if (cram_rd.en !== 1'b0) report_mismatch("cram_rd.en", cram_rd.en, 0);
		if (wram_rd.en !== 1'b0) report_mismatch("wram_rd.en", wram_rd.en, 0);
		if (bram_rd.en !== 1'b0) report_mismatch("bram_rd.en", bram_rd.en, 0);
		if (ldm_rd.en !== 1'b0) report_mismatch("ldm_rd.en", ldm_rd.en, 0);
		if (pe_ctl.en !== 1'b0) report_mismatch("pe_ctl.en", pe_ctl.en, 0);
		if (layer_done !== 1'b0) report_mismatch("layer_done", layer_done, 0);
		if (complete !== 1'b0) report_mismatch("complete", complete, 0);
		apb_read(REG_STATUS, rd, err);
		if (rd !== 32'h0) report_mismatch("REG_STATUS", rd, 0);
		// no register lives at 0xc
		apb_read(4'hc, rd, err);
		if (err !== 1'b1) report_mismatch("pslverr", err, 1);
		if (rd !== 32'h0) report_mismatch("prdata", rd, 0);
		$display("reset and register checks: %0d errors", test_errs);
		p = 0;
		while (!timed_out && !$isunknown(tdata[p]) && tdata[p] != 8'hff) begin
			max_a = tdata[p];
			p++;
			for (l = 0; l <= max_a; l++) begin
				ctx_mem[l] = unpack_ctx(p);
				p += 9;
			end
			run_test(max_a);
			tests_run++;
			if (test_errs == 0 && !timed_out) tests_ok++;
			$display("test %0d: %0d layers, %0d errors, %s", tests_run, max_a + 1,
				test_errs, (test_errs == 0 && !timed_out) ? "ok" : "FAIL");
		end
		$display("%0d tests run, %0d passed, %0d errors", tests_run, tests_ok, err_total);
		if (err_total == 0 && !timed_out && tests_run > 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== logic/cgra_ctrl_top.sv ====
// ####################################################################
// convolution array layer sequencer top level
// ####################################################################
`timescale 1ns/1ps

module cgra_ctrl_top #(
	parameter int DRAIN_CYCLES = 3
) (
	input  logic                 CLK,
	input  logic                 RST,
	input  apb_pkg::apb_req_t    apb_req,
	output apb_pkg::apb_rsp_t    apb_rsp,
	output ctrl_pkg::cram_rd_t   cram_rd,
	input  ctrl_pkg::ctx_word_t  ctx_in,
	output ctrl_pkg::pe_ctl_t    pe_ctl,
	output ctrl_pkg::wram_rd_t   wram_rd,
	output ctrl_pkg::bram_rd_t   bram_rd,
	output ctrl_pkg::ldm_rd_t    ldm_rd,
	output ctrl_pkg::ldm_store_t ldm_store,
	output logic                 layer_done,
	output logic                 complete
);
	import ctrl_pkg::*;

	logic                   start;
	logic                   busy;
	logic                   exec;
	logic [CRAM_ADDR_W-1:0] max_addr;
	ctx_word_t              ctx;
	iter_t                  iter;

	apb_regs u_apb_regs (
		.CLK      (CLK),
		.RST      (RST),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.busy     (busy),
		.complete (complete),
		.start    (start),
		.max_addr (max_addr)
	);

	layer_fsm #(
		.DRAIN_CYCLES (DRAIN_CYCLES)
	) u_layer_fsm (
		.CLK        (CLK),
		.RST        (RST),
		.start      (start),
		.max_addr   (max_addr),
		.layer_done (layer_done),
		.ctx_in     (ctx_in),
		.cram_rd    (cram_rd),
		.ctx        (ctx),
		.exec       (exec),
		.busy       (busy),
		.complete   (complete)
	);

	loop_counter #(
		.DRAIN_CYCLES (DRAIN_CYCLES)
	) u_loop_counter (
		.CLK        (CLK),
		.RST        (RST),
		.exec       (exec),
		.ctx        (ctx),
		.iter       (iter),
		.layer_done (layer_done)
	);

	// not busy means idle, so bases restart with every run
	weight_bias_addr u_weight_bias_addr (
		.CLK       (CLK),
		.RST       (RST),
		.run_clear (~busy),
		.iter      (iter),
		.ctx       (ctx),
		.wram_rd   (wram_rd),
		.bram_rd   (bram_rd)
	);

	ldm_addr_gen u_ldm_addr_gen (
		.CLK       (CLK),
		.RST       (RST),
		.iter      (iter),
		.ctx       (ctx),
		.ldm_rd    (ldm_rd),
		.ldm_store (ldm_store),
		.pe_ctl    (pe_ctl)
	);

endmodule

// ==== logic/ldm_addr_gen.sv ====
// ####################################################################
// LDM read addresses, store target and PE control per iteration
// ####################################################################
`timescale 1ns/1ps

module ldm_addr_gen (
	input  logic                 CLK,
	input  logic                 RST,
	input  ctrl_pkg::iter_t      iter,
	input  ctrl_pkg::ctx_word_t  ctx,
	output ctrl_pkg::ldm_rd_t    ldm_rd,
	output ctrl_pkg::ldm_store_t ldm_store,
	output ctrl_pkg::pe_ctl_t    pe_ctl
);
	import ctrl_pkg::*;

	logic                  is_mac;
	logic [LDM_ADDR_W-1:0] k_step;
	logic [LDM_ADDR_W-1:0] mac_row;
	logic [LDM_ADDR_W-1:0] sweep_cnt;
	logic [LDM_ADDR_W-1:0] row;

	assign is_mac = (ctx.op == OP_MAC);

	// y<<stride is y*(1+stride) for a one bit stride
	assign k_step  = (LDM_ADDR_W'(ctx.y_max) + 1'b1) << ctx.stride;
	assign mac_row = (LDM_ADDR_W'(iter.y) << ctx.stride) + LDM_ADDR_W'(iter.k) * k_step;
	assign row     = is_mac ? mac_row : sweep_cnt;

	// finished j sweeps, restarts with every layer
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			sweep_cnt <= '0;
		end else if (!iter.valid) begin
			sweep_cnt <= '0;
		end else if (iter.j_last) begin
			sweep_cnt <= sweep_cnt + 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			ldm_rd    <= '0;
			ldm_store <= '0;
			pe_ctl    <= '0;
		end else begin
			ldm_rd.en          <= iter.valid;
			ldm_rd.addr_a.bank <= ctx.src_bank;
			ldm_rd.addr_a.row  <= row;
			ldm_rd.addr_b.bank <= ctx.src_bank;
			ldm_rd.addr_b.row  <= row + 1'b1;
			ldm_store.dst_bank <= ctx.dst_bank;
			ldm_store.st_addr  <= ctx.st_addr;
			pe_ctl.en          <= iter.valid;
			pe_ctl.op          <= ctx.op;
			pe_ctl.stride      <= ctx.stride;
		end
	end

endmodule

// ==== logic/weight_bias_addr.sv ====
// ####################################################################
// weight and bias read addresses for MAC layers
// ####################################################################
`timescale 1ns/1ps

module weight_bias_addr (
	input  logic                CLK,
	input  logic                RST,
	input  logic                run_clear,
	input  ctrl_pkg::iter_t     iter,
	input  ctrl_pkg::ctx_word_t ctx,
	output ctrl_pkg::wram_rd_t  wram_rd,
	output ctrl_pkg::bram_rd_t  bram_rd
);
	import ctrl_pkg::*;

	logic                   is_mac;
	logic                   layer_end;
	logic [WRAM_ADDR_W-1:0] j_len;
	logic [WRAM_ADDR_W-1:0] k_len;
	logic [WRAM_ADDR_W-1:0] kj_size;
	logic [WRAM_ADDR_W-1:0] layer_size;
	logic [WRAM_ADDR_W-1:0] w_offs;
	logic [WRAM_ADDR_W-1:0] w_base;
	logic [BRAM_ADDR_W-1:0] b_base;

	assign is_mac = (ctx.op == OP_MAC);

	// one kernel is (k_max+1)(j_max+1) weights, one layer has n_max+1 kernels
	assign j_len      = WRAM_ADDR_W'(ctx.j_max) + 1'b1;
	assign k_len      = WRAM_ADDR_W'(ctx.k_max) + 1'b1;
	assign kj_size    = k_len * j_len;
	assign layer_size = (WRAM_ADDR_W'(ctx.n_max) + 1'b1) * kj_size;
	assign w_offs     = WRAM_ADDR_W'(iter.n) * kj_size + WRAM_ADDR_W'(iter.k) * j_len
		+ WRAM_ADDR_W'(iter.j);

	assign layer_end = iter.valid & is_mac & (iter.n == ctx.n_max) & iter.y_last
		& iter.k_last & iter.j_last;

	// bases carry over from one MAC layer to the next within a run
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			w_base <= '0;
			b_base <= '0;
		end else if (run_clear) begin
			w_base <= '0;
			b_base <= '0;
		end else if (layer_end) begin
			w_base <= w_base + layer_size;
			b_base <= b_base + BRAM_ADDR_W'(ctx.n_max) + 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			wram_rd <= '0;
			bram_rd <= '0;
		end else begin
			wram_rd.en   <= iter.valid & is_mac;
			wram_rd.addr <= w_base + w_offs;
			// bias only once per output value
			bram_rd.en   <= iter.valid & is_mac & iter.k_last & iter.j_last;
			bram_rd.addr <= b_base + BRAM_ADDR_W'(iter.n);
		end
	end

endmodule

// ==== logic/loop_counter.sv ====
// ####################################################################
// nested n/y/k/j iteration counters and drain timer
// ####################################################################
`timescale 1ns/1ps

module loop_counter #(
	parameter int DRAIN_CYCLES = 3
) (
	input  logic                CLK,
	input  logic                RST,
	input  logic                exec,
	input  ctrl_pkg::ctx_word_t ctx,
	output ctrl_pkg::iter_t     iter,
	output logic                layer_done
);
	import ctrl_pkg::*;

	localparam int DRAIN_W = (DRAIN_CYCLES > 1) ? $clog2(DRAIN_CYCLES) : 1;

	logic [CNT_W-1:0]   n_cnt;
	logic [ROW_W-1:0]   y_cnt;
	logic [CNT_W-1:0]   k_cnt;
	logic [CNT_W-1:0]   j_cnt;
	logic               draining;
	logic [DRAIN_W-1:0] drain_cnt;
	logic               issue;
	logic               n_last;
	logic               y_last;
	logic               k_last;
	logic               j_last;
	logic               last_iter;

	assign issue     = exec & ~draining;
	assign n_last    = (n_cnt == ctx.n_max);
	assign y_last    = (y_cnt == ctx.y_max);
	assign k_last    = (k_cnt == ctx.k_max);
	assign j_last    = (j_cnt == ctx.j_max);
	assign last_iter = issue & n_last & y_last & k_last & j_last;

	assign layer_done = draining & (drain_cnt == DRAIN_W'(DRAIN_CYCLES - 1));

	always_comb begin
		iter.valid  = issue;
		iter.n      = n_cnt;
		iter.y      = y_cnt;
		iter.k      = k_cnt;
		iter.j      = j_cnt;
		iter.k_last = k_last;
		iter.j_last = j_last;
		iter.y_last = y_last;
	end

	// j fastest, then k, y, n
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			n_cnt <= '0;
			y_cnt <= '0;
			k_cnt <= '0;
			j_cnt <= '0;
		end else if (!exec) begin
			n_cnt <= '0;
			y_cnt <= '0;
			k_cnt <= '0;
			j_cnt <= '0;
		end else if (issue) begin
			if (!j_last) begin
				j_cnt <= j_cnt + 1'b1;
			end else begin
				j_cnt <= '0;
				if (!k_last) begin
					k_cnt <= k_cnt + 1'b1;
				end else begin
					k_cnt <= '0;
					if (!y_last) begin
						y_cnt <= y_cnt + 1'b1;
					end else begin
						y_cnt <= '0;
						if (n_last) begin
							n_cnt <= '0;
						end else begin
							n_cnt <= n_cnt + 1'b1;
						end
					end
				end
			end
		end
	end

	// waits for the PE pipeline to empty after the final iteration
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			draining  <= 1'b0;
			drain_cnt <= '0;
		end else if (!exec || layer_done) begin
			draining  <= 1'b0;
			drain_cnt <= '0;
		end else if (last_iter) begin
			draining  <= 1'b1;
			drain_cnt <= '0;
		end else if (draining) begin
			drain_cnt <= drain_cnt + 1'b1;
		end
	end

	a_cnt_in_range: assert property (@(posedge CLK) disable iff (!RST)
		exec |-> (n_cnt <= ctx.n_max) && (y_cnt <= ctx.y_max) &&
			(k_cnt <= ctx.k_max) && (j_cnt <= ctx.j_max));

endmodule

// ==== logic/layer_fsm.sv ====
// ####################################################################
// layer sequencer FSM, context pointer and context capture
// ####################################################################
`timescale 1ns/1ps

module layer_fsm #(
	parameter int DRAIN_CYCLES = 3
) (
	input  logic                             CLK,
	input  logic                             RST,
	input  logic                             start,
	input  logic [ctrl_pkg::CRAM_ADDR_W-1:0] max_addr,
	input  logic                             layer_done,
	input  ctrl_pkg::ctx_word_t              ctx_in,
	output ctrl_pkg::cram_rd_t               cram_rd,
	output ctrl_pkg::ctx_word_t              ctx,
	output logic                             exec,
	output logic                             busy,
	output logic                             complete
);
	import ctrl_pkg::*;

	layer_state_e           state;
	layer_state_e           state_nxt;
	logic [CRAM_ADDR_W-1:0] ctx_ptr;
	logic [CRAM_ADDR_W-1:0] exec_addr;

	// pointer already moved past the context in flight
	assign exec_addr = ctx_ptr - 1'b1;
	assign complete  = (state == ST_EXEC) & layer_done & (exec_addr == max_addr);

	assign exec         = (state == ST_EXEC);
	assign busy         = (state != ST_IDLE);
	assign cram_rd.en   = (state == ST_LOAD_CTX);
	assign cram_rd.addr = ctx_ptr;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (start) begin
					state_nxt = ST_LOAD_CTX;
				end
			end
			ST_LOAD_CTX: begin
				state_nxt = ST_CTX_WAIT;
			end
			ST_CTX_WAIT: begin
				state_nxt = ST_EXEC;
			end
			ST_EXEC: begin
				if (complete) begin
					state_nxt = ST_IDLE;
				end else if (layer_done) begin
					state_nxt = ST_LOAD_CTX;
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			state   <= ST_IDLE;
			ctx_ptr <= '0;
			ctx     <= '0;
		end else begin
			state <= state_nxt;
			if ((state == ST_IDLE) && start) begin
				ctx_ptr <= '0;
			end else if (state == ST_LOAD_CTX) begin
				ctx_ptr <= ctx_ptr + 1'b1;
			end
			// RAM data is valid one cycle after the enable
			if (state == ST_CTX_WAIT) begin
				ctx <= ctx_in;
			end
		end
	end

	a_done_in_exec: assert property (@(posedge CLK) disable iff (!RST)
		layer_done |-> (state == ST_EXEC));

	// even a single iteration layer runs the full drain before done
	a_min_exec_len: assert property (@(posedge CLK) disable iff (!RST)
		$rose(exec) |-> !layer_done [*DRAIN_CYCLES]);

endmodule

// ==== logic/apb_regs.sv ====
// ####################################################################
// APB register block: control, last context address, status
// ####################################################################
`timescale 1ns/1ps

module apb_regs (
	input  logic                             CLK,
	input  logic                             RST,
	input  apb_pkg::apb_req_t                apb_req,
	output apb_pkg::apb_rsp_t                apb_rsp,
	input  logic                             busy,
	input  logic                             complete,
	output logic                             start,
	output logic [ctrl_pkg::CRAM_ADDR_W-1:0] max_addr
);
	import apb_pkg::*;
	import ctrl_pkg::*;

	logic        access;
	logic        wr_access;
	logic        start_req;
	logic        start_refused;
	logic        addr_err;
	logic        done;
	logic [31:0] rd_data;

	// access phase completes in the same cycle
	assign access    = apb_req.psel & apb_req.penable;
	assign wr_access = access & apb_req.pwrite;

	assign start_req     = wr_access & (apb_req.paddr == REG_CTRL) & apb_req.pwdata[0];
	assign start         = start_req & ~busy;
	assign start_refused = start_req & busy;

	always_comb begin
		rd_data  = '0;
		addr_err = 1'b0;
		case (apb_req.paddr)
			REG_CTRL: begin
				// write only, reads as zero
				rd_data = '0;
			end
			REG_MAX: begin
				rd_data = 32'(max_addr);
			end
			REG_STATUS: begin
				rd_data = {30'd0, done, busy};
			end
			default: begin
				addr_err = 1'b1;
			end
		endcase
	end

	assign apb_rsp.prdata  = (access & ~apb_req.pwrite) ? rd_data : '0;
	assign apb_rsp.pslverr = access & (addr_err | start_refused);

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			max_addr <= '0;
		end else if (wr_access && (apb_req.paddr == REG_MAX)) begin
			max_addr <= apb_req.pwdata[CRAM_ADDR_W-1:0];
		end
	end

	// sticky done, a new run clears it
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			done <= 1'b0;
		end else if (start) begin
			done <= 1'b0;
		end else if (complete) begin
			done <= 1'b1;
		end
	end

	a_penable_needs_psel: assert property (@(posedge CLK) disable iff (!RST)
		$rose(apb_req.penable) |-> apb_req.psel);

endmodule

// ==== logic/apb_pkg.sv ====
// ####################################################################
// APB request/response structs and register map
// ####################################################################
package apb_pkg;

	// host side, no pready since every access is zero wait
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pslverr;
	} apb_rsp_t;

	// byte addresses of the register block
	typedef enum logic [3:0] {
		REG_CTRL   = 4'h0,
		REG_MAX    = 4'h4,
		REG_STATUS = 4'h8
	} apb_reg_e;

endpackage

// ==== logic/ctrl_pkg.sv ====
// ####################################################################
// sequencer definitions: context word layout, opcodes, layer states,
// iteration record and memory port structs
// ####################################################################
package ctrl_pkg;

	localparam int CNT_W       = 4;
	localparam int ROW_W       = 3;
	localparam int BANK_W      = 2;
	localparam int LDM_ADDR_W  = 8;
	localparam int WRAM_ADDR_W = 12;
	localparam int BRAM_ADDR_W = 8;
	localparam int CRAM_ADDR_W = 6;

	typedef enum logic [1:0] {
		OP_MAC     = 2'd0,
		OP_MAXPOOL = 2'd1,
		OP_ADD     = 2'd2,
		OP_RELU    = 2'd3
	} ctx_op_e;

	typedef enum logic [1:0] {
		ST_IDLE     = 2'd0,
		ST_LOAD_CTX = 2'd1,
		ST_CTX_WAIT = 2'd2,
		ST_EXEC     = 2'd3
	} layer_state_e;

	// one layer, msb first
	typedef struct packed {
		logic [1:0]             rsvd;
		logic [CNT_W-1:0]       n_max;
		logic [ROW_W-1:0]       y_max;
		logic [CNT_W-1:0]       k_max;
		logic [CNT_W-1:0]       j_max;
		ctx_op_e                op;
		// 0 is stride 1, 1 is stride 2
		logic                   stride;
		logic [BANK_W-1:0]      src_bank;
		logic [BANK_W-1:0]      dst_bank;
		logic [LDM_ADDR_W-1:0]  st_addr;
	} ctx_word_t;

	typedef struct packed {
		logic             valid;
		logic [CNT_W-1:0] n;
		logic [ROW_W-1:0] y;
		logic [CNT_W-1:0] k;
		logic [CNT_W-1:0] j;
		logic             k_last;
		logic             j_last;
		logic             y_last;
	} iter_t;

	typedef struct packed {
		logic                   en;
		logic [CRAM_ADDR_W-1:0] addr;
	} cram_rd_t;

	typedef struct packed {
		logic                   en;
		logic [WRAM_ADDR_W-1:0] addr;
	} wram_rd_t;

	typedef struct packed {
		logic                   en;
		logic [BRAM_ADDR_W-1:0] addr;
	} bram_rd_t;

	typedef struct packed {
		logic [BANK_W-1:0]     bank;
		logic [LDM_ADDR_W-1:0] row;
	} ldm_addr_t;

	typedef struct packed {
		logic      en;
		ldm_addr_t addr_a;
		ldm_addr_t addr_b;
	} ldm_rd_t;

	typedef struct packed {
		logic [BANK_W-1:0]     dst_bank;
		logic [LDM_ADDR_W-1:0] st_addr;
	} ldm_store_t;

	typedef struct packed {
		logic    en;
		ctx_op_e op;
		logic    stride;
	} pe_ctl_t;

endpackage
